/* all.f */
+incdir+dv
hdl/merge_pkg.sv
hdl/sync_fifo.sv
hdl/read_ahead_buf.sv
hdl/rr_bus_arbiter.sv
hdl/chan_merge_top.sv
dv/merge_tb.sv

/* dv/merge_vectors.svh */
// --------------------
// stimulus table for merge_tb, included inside the testbench module
// columns: ch0 wr, ch0 data, ch1 wr, ch1 data, stall, random data, idle gap
// rows flagged random replace both data fields with $urandom bits
// --------------------

`ifndef MERGE_VECTORS_SVH
`define MERGE_VECTORS_SVH

task automatic build_table();
  // --------------------
  // single-channel bursts
  // --------------------

  // ch0 samples, signed extremes included
  // expect out_ch 0, same order
  add_row(1'b1, 16'h0001, 1'b0, 16'h0000, 1'b0, 1'b0, 0);
  add_row(1'b1, 16'h7fff, 1'b0, 16'h0000, 1'b0, 1'b0, 0);
  add_row(1'b1, 16'h8000, 1'b0, 16'h0000, 1'b0, 1'b0, 0);
  add_row(1'b1, 16'hffff, 1'b0, 16'h0000, 1'b0, 1'b0, 20);

  // ch1 commands, opcode in the top nibble
  // ends with ch1 served last, so ch0 wins the next tie
  add_row(1'b0, 16'h0000, 1'b1, 16'ha123, 1'b0, 1'b0, 0);
  add_row(1'b0, 16'h0000, 1'b1, 16'h5fff, 1'b0, 1'b0, 0);
  add_row(1'b0, 16'h0000, 1'b1, 16'hf000, 1'b0, 1'b0, 0);
  add_row(1'b0, 16'h0000, 1'b1, 16'h3c3c, 1'b0, 1'b0, 20);

  // --------------------
  // round robin under stall
  // --------------------

  // 3 words on ch0, 6 on ch1, all held back
  add_row(1'b1, 16'h1111, 1'b1, 16'h1aaa, 1'b1, 1'b0, 0);
  add_row(1'b1, 16'h2222, 1'b1, 16'h2bbb, 1'b1, 1'b1, 0);
  add_row(1'b1, 16'h3333, 1'b1, 16'h3ccc, 1'b1, 1'b0, 0);
  add_row(1'b0, 16'h0000, 1'b1, 16'h4ddd, 1'b1, 1'b1, 0);
  add_row(1'b0, 16'h0000, 1'b1, 16'h5eee, 1'b1, 1'b0, 0);
  add_row(1'b0, 16'h0000, 1'b1, 16'h6fff, 1'b1, 1'b1, 0);

  // hold the stall with words waiting, no out_valid allowed
  add_row(1'b0, 16'h0000, 1'b0, 16'h0000, 1'b1, 1'b0, 8);

  // release: 0,1,0,1,0,1 then ch1 alone
  add_row(1'b0, 16'h0000, 1'b0, 16'h0000, 1'b0, 1'b0, 30);

  // --------------------
  // full flag on ch0
  // --------------------

  // fifo_depth + 2 writes under stall
  // buffer takes one, fifo takes 8, the last row meets full
  for (int i = 0; i < merge_pkg::fifo_depth + 2; i++) begin
    add_row(1'b1, 16'h0000, 1'b0, 16'h0000, 1'b1, 1'b1, 0);
  end
  add_row(1'b0, 16'h0000, 1'b0, 16'h0000, 1'b1, 1'b0, 4);

  // drain, accepted words in write order
  add_row(1'b0, 16'h0000, 1'b0, 16'h0000, 1'b0, 1'b0, 30);
endtask

`endif

/* dv/merge_tb.sv */
// --------------------
// testbench for chan_merge_top, table driven from merge_vectors.svh
// inputs change 1 time unit after the rising edge
// outputs sampled on the falling edge, stops at the first error
// --------------------

module merge_tb;

  // one table row
  typedef struct packed {
    logic       c0_wr;
    logic [15:0] c0_data;
    logic       c1_wr;
    logic [15:0] c1_data;
    logic       stall;
    logic       rnd;
    logic [7:0] gap;
  } row_t;

  // --------------------
  // dut signals
  // --------------------

  logic                 clk;
  logic                 anrst;
  logic                 ch0_wr;
  merge_pkg::sample_t   ch0_data;
  logic                 ch0_full;
  logic                 ch1_wr;
  merge_pkg::cmd_t      ch1_data;
  logic                 ch1_full;
  logic                 out_stall;
  logic                 out_valid;
  merge_pkg::chan_id_t  out_ch;
  merge_pkg::bus_word_t out_data;

  // --------------------
  // scoreboard state
  // --------------------

  row_t                 rows [$];
  merge_pkg::bus_word_t q0 [$];
  merge_pkg::bus_word_t q1 [$];
  merge_pkg::bus_word_t exp_word;

  // round-robin model, ch1 counts as served at reset
  merge_pkg::chan_id_t  last_served = 1'b1;

  logic stall_q = 1'b0;
  logic saw_full0 = 1'b0;
  int   cycle_cnt = 0;
  int   cycle_limit = 0;

  chan_merge_top dut (
    .clk       (clk),
    .anrst     (anrst),
    .ch0_wr    (ch0_wr),
    .ch0_data  (ch0_data),
    .ch0_full  (ch0_full),
    .ch1_wr    (ch1_wr),
    .ch1_data  (ch1_data),
    .ch1_full  (ch1_full),
    .out_stall (out_stall),
    .out_valid (out_valid),
    .out_ch    (out_ch),
    .out_data  (out_data)
  );

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic add_row(input logic c0_wr, input logic [15:0] c0_data,
                         input logic c1_wr, input logic [15:0] c1_data,
                         input logic stall, input logic rnd, input int gap);
    row_t r;
    r.c0_wr   = c0_wr;
    r.c0_data = c0_data;
    r.c1_wr   = c1_wr;
    r.c1_data = c1_data;
    r.stall   = stall;
    r.rnd     = rnd;
    r.gap     = 8'(gap);
    rows.push_back(r);
  endtask

  `include "merge_vectors.svh"

  // drive one row, then idle for its gap, ends 1 unit after an edge
  task automatic apply_row(input row_t r);
    merge_pkg::bus_word_t d0;
    merge_pkg::bus_word_t d1;
    d0 = r.c0_data;
    d1 = r.c1_data;
    if (r.rnd) begin
      d0 = 16'($urandom);
      d1 = 16'($urandom);
    end
    // full needs at least fifo_depth words still held in that channel
    assert (!ch0_full || q0.size() >= merge_pkg::fifo_depth)
      else report_fail($sformatf("ERR ch0_full=%h expected=%h", ch0_full, 1'b0));
    assert (!ch1_full || q1.size() >= merge_pkg::fifo_depth)
      else report_fail($sformatf("ERR ch1_full=%h expected=%h", ch1_full, 1'b0));
    // a full channel is not written, the word is simply skipped
    if (r.c0_wr && ch0_full) begin
      saw_full0 = 1'b1;
    end
    ch0_wr    = r.c0_wr && !ch0_full;
    ch1_wr    = r.c1_wr && !ch1_full;
    ch0_data  = merge_pkg::sample_t'(d0);
    ch1_data  = merge_pkg::cmd_t'(d1);
    out_stall = r.stall;
    if (ch0_wr) begin
      q0.push_back(d0);
    end
    if (ch1_wr) begin
      q1.push_back(d1);
    end
    @(posedge clk);
    #1;
    ch0_wr = 1'b0;
    ch1_wr = 1'b0;
    repeat (r.gap) begin
      @(posedge clk);
      #1;
    end
  endtask

  // --------------------
  // clock and timeout
  // --------------------

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    stall_q <= out_stall;
    cycle_cnt = cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
      if (q0.size() != 0 || q1.size() != 0) begin
        report_fail("timeout with words still expected, words were lost");
      end else begin
        report_fail("timeout before the run finished");
      end
    end
  end

  // --------------------
  // output monitor
  // --------------------

  always @(negedge clk) begin
    if (anrst && out_valid) begin
      assert (!stall_q) else report_fail("out_valid appeared while out_stall was high");
      // strict alternation while both channels hold words
      if (q0.size() > 0 && q1.size() > 0) begin
        assert (out_ch != last_served)
          else report_fail($sformatf("ERR out_ch=%h expected=%h", out_ch, !last_served));
      end
      last_served = out_ch;
      if (out_ch == 1'b0) begin
        assert (q0.size() > 0) else report_fail("word on channel 0 with nothing expected");
        exp_word = q0.pop_front();
      end else begin
        assert (q1.size() > 0) else report_fail("word on channel 1 with nothing expected");
        exp_word = q1.pop_front();
      end
      assert (out_data === exp_word)
        else report_fail($sformatf("ERR out_data=%h expected=%h", out_data, exp_word));
    end
  end

  // --------------------
  // main sequence
  // --------------------

  initial begin
    int nwords;
    int ncycles;
    void'($urandom(9992));
    anrst     = 1'b0;
    ch0_wr    = 1'b0;
    ch0_data  = '0;
    ch1_wr    = 1'b0;
    ch1_data  = '0;
    out_stall = 1'b0;

    // limit from table length and word count
    build_table();
    nwords  = 0;
    ncycles = 0;
    foreach (rows[i]) begin
      nwords  = nwords + int'(rows[i].c0_wr) + int'(rows[i].c1_wr);
      ncycles = ncycles + 1 + int'(rows[i].gap);
    end
    cycle_limit = 3 + ncycles + 4 * nwords + 50;

    // reset, outputs must stay idle
    repeat (3) begin
      @(posedge clk);
      #1;
      assert (!out_valid && !ch0_full && !ch1_full)
        else report_fail("outputs not idle during reset");
    end
    anrst = 1'b1;

    foreach (rows[i]) begin
      apply_row(rows[i]);
    end

    // drain, then a quiet tail for stray words
    while (q0.size() != 0 || q1.size() != 0) begin
      @(posedge clk);
    end
    repeat (10) @(posedge clk);

    if (!saw_full0) begin
      report_fail("channel 0 full flag never rose");
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

/* hdl/chan_merge_top.sv */
// --------------------
// two-channel word merger, samples on ch0, commands on ch1
// writing a channel while its full flag is high loses that word
// out_valid marks each delivered word, latency varies
// --------------------

module chan_merge_top (
  input  logic                   clk,
  input  logic                   anrst,

  // channel 0 source
  input  logic                   ch0_wr,
  input  merge_pkg::sample_t     ch0_data,
  output logic                   ch0_full,

  // channel 1 source
  input  logic                   ch1_wr,
  input  merge_pkg::cmd_t        ch1_data,
  output logic                   ch1_full,

  // merged output
  input  logic                   out_stall,
  output logic                   out_valid,
  output merge_pkg::chan_id_t    out_ch,
  output merge_pkg::bus_word_t   out_data
);

  // --------------------
  // channel 0 pipeline
  // --------------------

  // fifo to buffer
  logic               f0_rd;
  merge_pkg::sample_t f0_rd_data;
  logic               f0_empty;

  // buffer to arbiter
  merge_pkg::sample_t b0_data;
  logic               b0_empty;
  logic               b0_pop;

  sync_fifo #(
    .payload_t (merge_pkg::sample_t)
  ) u_fifo0 (
    .clk        (clk),
    .anrst      (anrst),
    .wr         (ch0_wr),
    .wr_data    (ch0_data),
    .full       (ch0_full),
    .rd         (f0_rd),
    .rd_data    (f0_rd_data),
    .fifo_empty (f0_empty)
  );

  read_ahead_buf #(
    .payload_t (merge_pkg::sample_t)
  ) u_rab0 (
    .clk         (clk),
    .anrst       (anrst),
    .fifo_r_req  (f0_rd),
    .fifo_r_data (f0_rd_data),
    .fifo_empty  (f0_empty),
    .r_req       (b0_pop),
    .r_data      (b0_data),
    .empty       (b0_empty)
  );

  // --------------------
  // channel 1 pipeline
  // --------------------

  logic            f1_rd;
  merge_pkg::cmd_t f1_rd_data;
  logic            f1_empty;

  merge_pkg::cmd_t b1_data;
  logic            b1_empty;
  logic            b1_pop;

  sync_fifo #(
    .payload_t (merge_pkg::cmd_t)
  ) u_fifo1 (
    .clk        (clk),
    .anrst      (anrst),
    .wr         (ch1_wr),
    .wr_data    (ch1_data),
    .full       (ch1_full),
    .rd         (f1_rd),
    .rd_data    (f1_rd_data),
    .fifo_empty (f1_empty)
  );

  read_ahead_buf #(
    .payload_t (merge_pkg::cmd_t)
  ) u_rab1 (
    .clk         (clk),
    .anrst       (anrst),
    .fifo_r_req  (f1_rd),
    .fifo_r_data (f1_rd_data),
    .fifo_empty  (f1_empty),
    .r_req       (b1_pop),
    .r_data      (b1_data),
    .empty       (b1_empty)
  );

  // --------------------
  // shared bus
  // --------------------

  rr_bus_arbiter u_arb (
    .clk       (clk),
    .anrst     (anrst),
    .empty0    (b0_empty),
    .data0     (b0_data),
    .pop0      (b0_pop),
    .empty1    (b1_empty),
    .data1     (b1_data),
    .pop1      (b1_pop),
    .out_stall (out_stall),
    .out_valid (out_valid),
    .out_ch    (out_ch),
    .out_data  (out_data)
  );

endmodule

/* hdl/merge_pkg.sv */
// --------------------
// shared types and sizes for the two-channel merger
// fifo_depth must be a power of two, pointers wrap naturally
// both payloads are 16 bits and ride the bus word bit for bit
// --------------------

package merge_pkg;

  // --------------------
  // sizes
  // --------------------

  // shared output bus word width
  localparam int word_w = 16;

  // entries per channel fifo
  localparam int fifo_depth = 8;

  // fifo pointer width, occupancy counter is one bit wider
  localparam int ptr_w = $clog2(fifo_depth);

  // --------------------
  // payload types
  // --------------------

  // channel 0, signed sensor sample
  typedef logic signed [15:0] sample_t;

  // channel 1, command word
  // opcode in the top nibble, argument below
  typedef struct packed {
    logic [3:0]  opcode;
    logic [11:0] arg;
  } cmd_t;

  // --------------------
  // output bus types
  // --------------------

  // merged word as seen downstream
  typedef logic [word_w-1:0] bus_word_t;

  // channel tag, 0 = samples, 1 = commands
  typedef logic chan_id_t;

endpackage

/* hdl/read_ahead_buf.sv */
// --------------------
// turns a registered-read fifo into a fwft source
// r_data is valid whenever empty is low
// pop with r_req only while empty is low
// after a pop, empty rises for at least one cycle during refetch
// --------------------

module read_ahead_buf #(
  parameter type payload_t = merge_pkg::bus_word_t
) (
  input  logic     clk,
  input  logic     anrst,

  // fifo side
  output logic     fifo_r_req,
  input  payload_t fifo_r_data,
  input  logic     fifo_empty,

  // consumer side
  input  logic     r_req,
  output payload_t r_data,
  output logic     empty
);

  // --------------------
  // state
  // --------------------

  // head word currently on display
  payload_t head;

  // head holds a word
  logic head_vld;

  // fifo read issued last cycle, data lands this cycle
  logic fetch_pend;

  // register counts as free when empty or being popped right now
  logic slot_free;

  assign slot_free = !head_vld || r_req;

  // one fetch at a time, so the request never lasts two cycles
  assign fifo_r_req = slot_free && !fifo_empty && !fetch_pend;

  // --------------------
  // control
  // --------------------

  always_ff @(posedge clk or negedge anrst) begin
    if (!anrst) begin
      head_vld   <= 1'b0;
      fetch_pend <= 1'b0;
    end else begin
      fetch_pend <= fifo_r_req;

      // fetched word arrives, head becomes valid
      // a pop cannot coincide, head is invalid while a fetch is pending
      if (fetch_pend) begin
        head_vld <= 1'b1;
      end else if (r_req) begin
        head_vld <= 1'b0;
      end
    end
  end

  // --------------------
  // holding register
  // --------------------

  // capture fifo output one cycle after the request
  always_ff @(posedge clk) begin
    if (fetch_pend) begin
      head <= fifo_r_data;
    end
  end

  // fall-through view
  assign r_data = head;
  assign empty  = !head_vld;

endmodule

/* hdl/rr_bus_arbiter.sv */
// --------------------
// round-robin pick between two fwft channels
// pop at edge N gives out_valid for the cycle after N
// out_ch and out_data hold until the next out_valid
// out_stall blocks every grant
// --------------------

module rr_bus_arbiter (
  input  logic                   clk,
  input  logic                   anrst,

  // channel 0, samples
  input  logic                   empty0,
  input  merge_pkg::sample_t     data0,
  output logic                   pop0,

  // channel 1, commands
  input  logic                   empty1,
  input  merge_pkg::cmd_t        data1,
  output logic                   pop1,

  // downstream
  input  logic                   out_stall,
  output logic                   out_valid,
  output merge_pkg::chan_id_t    out_ch,
  output merge_pkg::bus_word_t   out_data
);

  // --------------------
  // grant decision
  // --------------------

  // channel served most recently
  merge_pkg::chan_id_t last_ch;

  logic req0;
  logic req1;
  logic grant0;
  logic grant1;

  assign req0 = !empty0;
  assign req1 = !empty1;

  always_comb begin
    grant0 = 1'b0;
    grant1 = 1'b0;
    if (!out_stall) begin
      if (req0 && req1) begin
        // tie goes to the channel not served last
        grant0 = (last_ch == 1'b1);
        grant1 = (last_ch == 1'b0);
      end else begin
        grant0 = req0;
        grant1 = req1;
      end
    end
  end

  // pop pulses straight from the grant
  assign pop0 = grant0;
  assign pop1 = grant1;

  // --------------------
  // output stage
  // --------------------

  always_ff @(posedge clk or negedge anrst) begin
    if (!anrst) begin
      out_valid <= 1'b0;
      // channel 0 wins the first tie
      last_ch   <= 1'b1;
    end else begin
      out_valid <= grant0 || grant1;
      if (grant0) begin
        last_ch <= 1'b0;
      end else if (grant1) begin
        last_ch <= 1'b1;
      end
    end
  end

  // word and tag, both payloads copied bit for bit
  always_ff @(posedge clk) begin
    if (grant0) begin
      out_ch   <= 1'b0;
      out_data <= merge_pkg::bus_word_t'(data0);
    end else if (grant1) begin
      out_ch   <= 1'b1;
      out_data <= merge_pkg::bus_word_t'(data1);
    end
  end

endmodule

/* hdl/sync_fifo.sv */
// --------------------
// single-clock fifo, depth from merge_pkg::fifo_depth
// rd_data is registered and valid one cycle after rd
// writes while full and reads while empty are ignored
// --------------------

module sync_fifo #(
  parameter type payload_t = merge_pkg::bus_word_t
) (
  input  logic     clk,
  input  logic     anrst,

  // write side
  input  logic     wr,
  input  payload_t wr_data,
  output logic     full,

  // read side
  input  logic     rd,
  output payload_t rd_data,
  output logic     fifo_empty
);

  // --------------------
  // storage and pointers
  // --------------------

  payload_t mem [merge_pkg::fifo_depth];

  logic [merge_pkg::ptr_w-1:0] wr_ptr;
  logic [merge_pkg::ptr_w-1:0] rd_ptr;

  // occupancy, one bit wider to reach fifo_depth
  logic [merge_pkg::ptr_w:0] count;

  // qualified strobes
  logic wr_en;
  logic rd_en;

  assign wr_en = wr && !full;
  assign rd_en = rd && !fifo_empty;

  // flags straight off the counter
  assign full       = (count == (merge_pkg::ptr_w + 1)'(merge_pkg::fifo_depth));
  assign fifo_empty = (count == '0);

  // --------------------
  // control state
  // --------------------

  always_ff @(posedge clk or negedge anrst) begin
    if (!anrst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // pointers wrap at the power-of-two depth
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end

      // simultaneous push and pop leaves count alone
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // --------------------
  // memory and read port
  // --------------------

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // block-ram style registered read
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_ptr];
    end
  end

endmodule
